/* src/soc_pkg.sv */
package soc_pkg;

    // ------------------------------------------------
    // device bus geometry
    // ------------------------------------------------
    localparam int XLEN_DEF    = 32; // data and address width of the i/o bus
    localparam int AXIL_ADDR_W = 7;  // register space of the sd-card spi controller

    // ------------------------------------------------
    // reset sequencing
    // ------------------------------------------------
    // core stays in reset this many cycles after rst drops
    // so that all pipeline registers settle
    localparam int RST_HOLD_DEF = 8;

    // ------------------------------------------------
    // bus word types
    // ------------------------------------------------
    typedef logic [XLEN_DEF-1:0]   dev_word_t; // one bus word
    typedef logic [XLEN_DEF/8-1:0] dev_be_t;   // one enable per byte lane

endpackage

/* src/dev_map_pkg.sv */
package dev_map_pkg;

    // ------------------------------------------------
    // device address map
    // ------------------------------------------------
    // decode looks only at the top address byte
    //   0xC000_0000 .. 0xC0FF_FFFF  uart
    //   0xC200_0000 .. 0xC2FF_FFFF  sd-card spi
    localparam int PAGE_W = 8;

    localparam logic [PAGE_W-1:0] UART_PAGE = 8'hC0; // uart page
    localparam logic [PAGE_W-1:0] SPI_PAGE  = 8'hC2; // spi page

    // ------------------------------------------------
    // decoded region
    // ------------------------------------------------
    typedef enum logic [1:0] {
        DEV_NONE, // unmapped, nobody answers
        DEV_UART, // combinational uart path
        DEV_SPI   // axi-lite read bridge
    } dev_region_e;

endpackage

/* src/dev_bus_if.sv */
`timescale 1ns/100ps

// one device's slice of the core i/o bus
interface dev_bus_if;
    import soc_pkg::*;

    logic      strobe; // one-cycle request, already region qualified
    dev_word_t addr;   // full byte address
    logic      we;     // write flag
    dev_word_t rdata;  // read word, valid with ready
    logic      ready;  // one-cycle pulse, ends the access

    // decoder side
    modport host (
        output strobe,
        output addr,
        output we,
        input  rdata,
        input  ready
    );

    // peripheral side
    modport target (
        input  strobe,
        input  addr,
        input  we,
        output rdata,
        output ready
    );

endinterface

/* src/reset_stretch.sv */
`timescale 1ns/100ps

module reset_stretch #(
    parameter int RST_HOLD = soc_pkg::RST_HOLD_DEF
) (
    input  logic clk,
    input  logic rst,
    output logic core_rst_o
);

    // at least one bit even for a zero hold
    localparam int CNT_W = $clog2(RST_HOLD + 2);

    logic [CNT_W-1:0] hold_cnt; // cycles left until the core is released

    // ------------------------------------------------
    // hold counter
    // ------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            hold_cnt <= CNT_W'(RST_HOLD);     // reload while system reset is on
        else if (hold_cnt != '0)
            hold_cnt <= hold_cnt - 1'b1;      // count down, stick at zero
    end

    // registered core reset
    always_ff @(posedge clk)
    begin
        core_rst_o <= rst | (hold_cnt != '0);
    end

    // core never leaves reset in the cycle right after a system reset
    a_rst_follows: assert property (@(posedge clk) rst |=> core_rst_o)
        else $error("core reset low right after system reset");

endmodule

/* src/dev_decoder.sv */
`timescale 1ns/100ps

module dev_decoder #(
    parameter int XLEN = soc_pkg::XLEN_DEF
) (
    input  logic               clk,
    input  logic               rst,

    // core side
    input  logic               dev_strobe_i,
    input  soc_pkg::dev_word_t dev_addr_i,
    input  logic               dev_we_i,
    input  soc_pkg::dev_be_t   dev_be_i,
    input  soc_pkg::dev_word_t dev_wdata_i,
    output soc_pkg::dev_word_t dev_rdata_o,
    output logic               dev_ready_o,

    // uart side
    output logic               uart_en_o,
    output logic [1:0]         uart_addr_o,
    output logic               uart_we_o,
    output soc_pkg::dev_be_t   uart_be_o,
    output soc_pkg::dev_word_t uart_wdata_o,
    input  soc_pkg::dev_word_t uart_rdata_i,
    input  logic               uart_ready_i,

    // spi side
    dev_bus_if.host            spi
);
    import dev_map_pkg::*;

    logic [PAGE_W-1:0] page;   // top address byte
    dev_region_e       region; // decoded target

    // ------------------------------------------------
    // region decode
    // ------------------------------------------------
    assign page = dev_addr_i[XLEN-1 -: PAGE_W];

    always_comb
    begin
        case (page)
            UART_PAGE: region = DEV_UART;
            SPI_PAGE:  region = DEV_SPI;
            default:   region = DEV_NONE;
        endcase
    end

    // ------------------------------------------------
    // request fan-out
    // ------------------------------------------------
    assign uart_en_o    = dev_strobe_i & (region == DEV_UART);
    assign uart_addr_o  = dev_addr_i[3:2]; // word select inside the uart
    assign uart_we_o    = dev_we_i;
    assign uart_be_o    = dev_be_i;
    assign uart_wdata_o = dev_wdata_i;

    assign spi.strobe = dev_strobe_i & (region == DEV_SPI);
    assign spi.addr   = dev_addr_i;   // bridge picks its own low bits
    assign spi.we     = dev_we_i;

    // ------------------------------------------------
    // response mux
    // ------------------------------------------------
    // ready is a single bit, unmapped reads give zero
    always_comb
    begin
        case (region)
            DEV_UART:
            begin
                dev_rdata_o = uart_rdata_i;
                dev_ready_o = uart_ready_i;
            end
            DEV_SPI:
            begin
                dev_rdata_o = spi.rdata;
                dev_ready_o = spi.ready;
            end
            default:
            begin
                dev_rdata_o = '0;
                dev_ready_o = 1'b0;
            end
        endcase
    end

    // an unmapped access never completes
    a_no_ready_unmapped: assert property (@(posedge clk) disable iff (rst)
        $rose(dev_ready_o) |-> (region != DEV_NONE))
        else $error("ready pulse on unmapped address %h", dev_addr_i);

endmodule

/* src/axil_rd_bridge.sv */
`timescale 1ns/100ps

module axil_rd_bridge #(
    parameter int XLEN        = soc_pkg::XLEN_DEF,
    parameter int AXIL_ADDR_W = soc_pkg::AXIL_ADDR_W
) (
    input  logic                   clk,
    input  logic                   rst,

    // device bus from the decoder
    dev_bus_if.target              dev,

    // axi-lite read channels toward the spi controller
    output logic [AXIL_ADDR_W-1:0] m_araddr_o,
    output logic                   m_arvalid_o,
    output logic                   m_rready_o,
    input  logic                   m_arready_i,
    input  logic                   m_rvalid_i,
    input  soc_pkg::dev_word_t     m_rdata_i
);
    import dev_map_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE, // waiting for a read strobe
        ST_ADDR, // ar phase, arvalid up
        ST_DATA, // r phase, waiting for rvalid
        ST_DONE  // ready pulse to the core
    } state_e;

    localparam dev_region_e OWN_REGION = DEV_SPI; // region served here

    state_e          state;
    state_e          state_nx;
    logic [XLEN-1:0] rdata_q; // last word seen on the r channel
    logic            rd_req;  // read request this cycle
    logic            ar_beat; // address handshake
    logic            r_beat;  // data handshake

    assign rd_req  = dev.strobe & ~dev.we;
    assign ar_beat = m_arvalid_o & m_arready_i;
    assign r_beat  = m_rvalid_i & m_rready_o;

    // ------------------------------------------------
    // sequencer
    // ------------------------------------------------
    always_comb
    begin
        state_nx = state;
        case (state)
            ST_IDLE:
                if (rd_req)
                    state_nx = ST_ADDR;
            ST_ADDR:
                if (ar_beat)
                    state_nx = ST_DATA;
            ST_DATA:
                if (r_beat)
                    state_nx = ST_DONE;
            ST_DONE:
                state_nx = ST_IDLE;    // ready lasts one cycle
            default:
                state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= ST_IDLE;
        else
            state <= state_nx;
    end

    // ------------------------------------------------
    // read address channel
    // ------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            m_arvalid_o <= 1'b0;
        else if (state == ST_IDLE && rd_req)
            m_arvalid_o <= 1'b1;       // up the cycle after the strobe
        else if (ar_beat)
            m_arvalid_o <= 1'b0;       // drop once the slave took it
    end

    // address latched once per read, stable through the ar phase
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && rd_req)
            m_araddr_o <= dev.addr[AXIL_ADDR_W-1:0];
    end

    // ------------------------------------------------
    // read data channel
    // ------------------------------------------------
    // one-cycle rready right after rvalid shows up
    always_ff @(posedge clk)
    begin
        if (rst)
            m_rready_o <= 1'b0;
        else if (state == ST_DATA && m_rvalid_i && !m_rready_o)
            m_rready_o <= 1'b1;
        else
            m_rready_o <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            rdata_q <= '0;
        else if (m_rvalid_i)
            rdata_q <= m_rdata_i;      // keep until the next rvalid
    end

    assign dev.rdata = rdata_q;
    assign dev.ready = (state == ST_DONE);

    // ------------------------------------------------
    // checks
    // ------------------------------------------------
    a_no_write: assert property (@(posedge clk) disable iff (rst)
        dev.strobe |-> !dev.we)
        else $error("write to %s region is unsupported", OWN_REGION.name());

    // host waits for ready before the next strobe
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        dev.strobe |-> (state == ST_IDLE))
        else $error("strobe while a read is still in flight");

    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        (m_arvalid_o && !m_arready_i) |=> (m_arvalid_o && $stable(m_araddr_o)))
        else $error("arvalid dropped or araddr changed before arready");

endmodule

/* src/dev_fabric_top.sv */
`timescale 1ns/100ps

module dev_fabric_top #(
    parameter int XLEN        = soc_pkg::XLEN_DEF,
    parameter int AXIL_ADDR_W = soc_pkg::AXIL_ADDR_W,
    parameter int RST_HOLD    = soc_pkg::RST_HOLD_DEF
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   core_rst_o,   // stretched reset to the core

    // core i/o bus
    input  logic                   dev_strobe_i,
    input  logic [XLEN-1:0]        dev_addr_i,
    input  logic                   dev_we_i,
    input  logic [XLEN/8-1:0]      dev_be_i,
    input  logic [XLEN-1:0]        dev_wdata_i,
    output logic [XLEN-1:0]        dev_rdata_o,
    output logic                   dev_ready_o,

    // uart register port
    output logic                   uart_en_o,
    output logic [1:0]             uart_addr_o,
    output logic                   uart_we_o,
    output logic [XLEN/8-1:0]      uart_be_o,
    output logic [XLEN-1:0]        uart_wdata_o,
    input  logic [XLEN-1:0]        uart_rdata_i,
    input  logic                   uart_ready_i,

    // axi-lite read master to the sd-card spi controller
    output logic [AXIL_ADDR_W-1:0] m_araddr_o,
    output logic                   m_arvalid_o,
    output logic                   m_rready_o,
    input  logic                   m_arready_i,
    input  logic                   m_rvalid_i,
    input  logic [XLEN-1:0]        m_rdata_i
);

    dev_bus_if spi_bus (); // decoder to bridge

    // ------------------------------------------------
    // reset stretcher
    // ------------------------------------------------
    reset_stretch #(
        .RST_HOLD   (RST_HOLD)
    ) u_reset_stretch (
        .clk        (clk),
        .rst        (rst),
        .core_rst_o (core_rst_o)
    );

    // ------------------------------------------------
    // address decoder
    // ------------------------------------------------
    // decoder and bridge leave reset with the core
    dev_decoder #(
        .XLEN         (XLEN)
    ) u_dev_decoder (
        .clk          (clk),
        .rst          (core_rst_o),
        .dev_strobe_i (dev_strobe_i),
        .dev_addr_i   (dev_addr_i),
        .dev_we_i     (dev_we_i),
        .dev_be_i     (dev_be_i),
        .dev_wdata_i  (dev_wdata_i),
        .dev_rdata_o  (dev_rdata_o),
        .dev_ready_o  (dev_ready_o),
        .uart_en_o    (uart_en_o),
        .uart_addr_o  (uart_addr_o),
        .uart_we_o    (uart_we_o),
        .uart_be_o    (uart_be_o),
        .uart_wdata_o (uart_wdata_o),
        .uart_rdata_i (uart_rdata_i),
        .uart_ready_i (uart_ready_i),
        .spi          (spi_bus.host)
    );

    // ------------------------------------------------
    // spi read bridge
    // ------------------------------------------------
    axil_rd_bridge #(
        .XLEN        (XLEN),
        .AXIL_ADDR_W (AXIL_ADDR_W)
    ) u_axil_rd_bridge (
        .clk         (clk),
        .rst         (core_rst_o),
        .dev         (spi_bus.target),
        .m_araddr_o  (m_araddr_o),
        .m_arvalid_o (m_arvalid_o),
        .m_rready_o  (m_rready_o),
        .m_arready_i (m_arready_i),
        .m_rvalid_i  (m_rvalid_i),
        .m_rdata_i   (m_rdata_i)
    );

endmodule

/* tb/tb_dev_fabric.sv */
`timescale 1ns/100ps

module tb_dev_fabric;

    localparam int          XLEN        = 32;
    localparam int          AXIL_ADDR_W = 7;
    localparam int          RST_HOLD    = 8;
    localparam int          CLK_PERIOD  = 8;
    localparam int          RST_CYCLES  = 8;
    localparam int          N_SPI       = 6;  // random spi reads
    localparam int          AR_STALL    = 5;  // arready held low this long
    localparam int          NUM_ACCESS  = 2 + N_SPI + 1 + 1;
    localparam int          WATCHDOG_CYCLES = RST_CYCLES + RST_HOLD + 1 + 200 * NUM_ACCESS;
    localparam int unsigned SEED        = 32'hb2d0_c7dc;

    logic                   clk;
    logic                   rst;
    logic                   core_rst_o;
    logic                   dev_strobe_i;
    logic [XLEN-1:0]        dev_addr_i;
    logic                   dev_we_i;
    logic [XLEN/8-1:0]      dev_be_i;
    logic [XLEN-1:0]        dev_wdata_i;
    logic [XLEN-1:0]        dev_rdata_o;
    logic                   dev_ready_o;
    logic                   uart_en_o;
    logic [1:0]             uart_addr_o;
    logic                   uart_we_o;
    logic [XLEN/8-1:0]      uart_be_o;
    logic [XLEN-1:0]        uart_wdata_o;
    logic [XLEN-1:0]        uart_rdata_i;
    logic                   uart_ready_i;
    logic [AXIL_ADDR_W-1:0] m_araddr_o;
    logic                   m_arvalid_o;
    logic                   m_rready_o;
    logic                   m_arready_i;
    logic                   m_rvalid_i;
    logic [XLEN-1:0]        m_rdata_i;

    int                     ar_hold_cycles = -1; // forced arready delay, -1 = random
    int unsigned            seed_ret;

    dev_fabric_top #(
        .XLEN        (XLEN),
        .AXIL_ADDR_W (AXIL_ADDR_W),
        .RST_HOLD    (RST_HOLD)
    ) UUT (
        .clk (clk), .rst (rst), .core_rst_o (core_rst_o),
        .dev_strobe_i (dev_strobe_i), .dev_addr_i (dev_addr_i), .dev_we_i (dev_we_i),
        .dev_be_i (dev_be_i), .dev_wdata_i (dev_wdata_i),
        .dev_rdata_o (dev_rdata_o), .dev_ready_o (dev_ready_o),
        .uart_en_o (uart_en_o), .uart_addr_o (uart_addr_o), .uart_we_o (uart_we_o),
        .uart_be_o (uart_be_o), .uart_wdata_o (uart_wdata_o),
        .uart_rdata_i (uart_rdata_i), .uart_ready_i (uart_ready_i),
        .m_araddr_o (m_araddr_o), .m_arvalid_o (m_arvalid_o), .m_rready_o (m_rready_o),
        .m_arready_i (m_arready_i), .m_rvalid_i (m_rvalid_i), .m_rdata_i (m_rdata_i)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // --------------------------------------------------
    // peripheral models
    // --------------------------------------------------
    // uart answers in the same cycle, word select back in the low byte
    assign uart_ready_i = uart_en_o;
    assign uart_rdata_i = uart_en_o ? (32'hA5A5_0000 | {28'h0, uart_addr_o, 2'b00}) : '0;

    // axi-lite slave, random delays on both phases
    initial
    begin : axil_slave
        int unsigned            delay;
        logic [AXIL_ADDR_W-1:0] ar_addr;
        m_arready_i = 1'b0;
        m_rvalid_i  = 1'b0;
        m_rdata_i   = '0;
        forever
        begin
            @(negedge clk);
            if (m_arvalid_o === 1'b1)
            begin
                if (ar_hold_cycles >= 0)
                    delay = ar_hold_cycles;
                else
                    delay = $urandom_range(5, 0);
                repeat (delay) @(negedge clk);
                ar_addr     = m_araddr_o;
                m_arready_i = 1'b1;      // beat on the next rising edge
                @(negedge clk);
                m_arready_i = 1'b0;
                delay = $urandom_range(5, 0);
                repeat (delay) @(negedge clk);
                m_rvalid_i = 1'b1;
                m_rdata_i  = 32'h5A00_0000 | 32'(ar_addr);
                @(negedge clk);
                while (m_rready_o !== 1'b1)
                    @(negedge clk);
                @(negedge clk);          // rready beat has passed
                m_rvalid_i = 1'b0;
                m_rdata_i  = '0;
            end
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    // one-cycle strobe, address stays up for the response mux
    task automatic start_access(input logic [XLEN-1:0] addr);
        @(negedge clk);
        dev_strobe_i = 1'b1;
        dev_addr_i   = addr;
        dev_we_i     = 1'b0;
        dev_be_i     = 4'hF;
        @(negedge clk);
        dev_strobe_i = 1'b0;
    endtask

    task automatic wait_for_ready(input logic [XLEN-1:0] exp);
        int waited;
        waited = 0;
        while (dev_ready_o !== 1'b1)
        begin
            @(negedge clk);
            waited++;
            assert (waited < 100)
                else stop_on_error("no ready pulse came back for the SPI read");
        end
        assert (dev_rdata_o === exp)
            else stop_on_error($sformatf("FAILED dev_rdata_o: got %h, expected %h",
                                         dev_rdata_o, exp));
        repeat (4)                       // exactly one pulse
        begin
            @(negedge clk);
            assert (dev_ready_o === 1'b0)
                else stop_on_error($sformatf("FAILED dev_ready_o: got %h, expected 0",
                                             dev_ready_o));
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic verify_reset_release();
        int n;
        repeat (RST_CYCLES)
        begin
            @(negedge clk);
            assert (core_rst_o === 1'b1)
                else stop_on_error($sformatf("FAILED core_rst_o: got %h, expected 1",
                                             core_rst_o));
        end
        rst = 1'b0;
        n   = 0;
        while (core_rst_o === 1'b1)
        begin
            @(negedge clk);
            n++;
            assert (n <= RST_HOLD + 2) else stop_on_error("core reset was never released");
        end
        assert (n >= RST_HOLD && n <= RST_HOLD + 1)
            else stop_on_error($sformatf(
                "FAILED core_rst_o release: got %h cycles, expected %h to %h",
                n, RST_HOLD, RST_HOLD + 1));
        assert (m_arvalid_o === 1'b0 && m_rready_o === 1'b0 && dev_ready_o === 1'b0)
            else stop_on_error("bus outputs not idle after reset");
    endtask

    // uart access, request fields pass straight through
    task automatic access_uart_reg(input logic            we,
                                   input logic [XLEN-1:0] addr,
                                   input logic [1:0]      exp_sel);
        logic [XLEN-1:0] exp;
        logic [XLEN-1:0] wdata;
        logic [3:0]      be;
        exp   = 32'hA5A5_0000 | {24'h0, addr[7:0]};
        wdata = $urandom;
        be    = 4'($urandom);
        @(negedge clk);
        dev_strobe_i = 1'b1;
        dev_addr_i   = addr;
        dev_we_i     = we;
        dev_be_i     = be;
        dev_wdata_i  = wdata;
        #(CLK_PERIOD/4);                 // mid low phase, path is combinational
        assert (uart_en_o === 1'b1)
            else stop_on_error($sformatf("FAILED uart_en_o: got %h, expected 1", uart_en_o));
        assert (uart_addr_o === exp_sel)
            else stop_on_error($sformatf("FAILED uart_addr_o: got %h, expected %h",
                                         uart_addr_o, exp_sel));
        assert (uart_we_o === we)
            else stop_on_error($sformatf("FAILED uart_we_o: got %h, expected %h",
                                         uart_we_o, we));
        assert (uart_be_o === be)
            else stop_on_error($sformatf("FAILED uart_be_o: got %h, expected %h",
                                         uart_be_o, be));
        assert (uart_wdata_o === wdata)
            else stop_on_error($sformatf("FAILED uart_wdata_o: got %h, expected %h",
                                         uart_wdata_o, wdata));
        assert (dev_ready_o === 1'b1)
            else stop_on_error($sformatf("FAILED dev_ready_o: got %h, expected 1", dev_ready_o));
        assert (dev_rdata_o === exp)
            else stop_on_error($sformatf("FAILED dev_rdata_o: got %h, expected %h",
                                         dev_rdata_o, exp));
        @(negedge clk);
        dev_strobe_i = 1'b0;
        dev_we_i     = 1'b0;
        dev_addr_i   = '0;
    endtask

    task automatic read_spi_regs();
        logic [XLEN-1:0] addr;
        for (int i = 0; i < N_SPI; i++)
        begin
            addr = 32'hC200_0000 | ($urandom & 32'h00FF_FFFF);
            start_access(addr);
            wait_for_ready(32'h5A00_0000 | (addr & 32'h0000_007F));
        end
        dev_addr_i = '0;
    endtask

    task automatic stall_address_phase();
        logic [XLEN-1:0]        addr;
        logic [AXIL_ADDR_W-1:0] exp_ar;
        int                     cycles;
        addr           = 32'hC213_37D5;
        exp_ar         = addr[AXIL_ADDR_W-1:0];
        ar_hold_cycles = AR_STALL;
        start_access(addr);
        dev_addr_i     = addr ^ 32'h0000_007F; // core moves on, araddr must not
        cycles = 0;
        assert (m_arvalid_o === 1'b1)
            else stop_on_error($sformatf("FAILED m_arvalid_o: got %h, expected 1", m_arvalid_o));
        while (m_arvalid_o === 1'b1)     // address must hold until the beat
        begin
            assert (m_araddr_o === exp_ar)
                else stop_on_error($sformatf("FAILED m_araddr_o: got %h, expected %h",
                                             m_araddr_o, exp_ar));
            @(negedge clk);
            cycles++;
        end
        ar_hold_cycles = -1;
        dev_addr_i     = addr;
        assert (cycles == AR_STALL + 1)
            else stop_on_error($sformatf("FAILED m_arvalid_o high time: got %h, expected %h",
                                         cycles, AR_STALL + 1));
        wait_for_ready(32'h5A00_0000 | (addr & 32'h0000_007F));
        dev_addr_i = '0;
    endtask

    task automatic probe_unmapped();
        @(negedge clk);
        dev_strobe_i = 1'b1;
        dev_addr_i   = 32'h4000_0000;
        #(CLK_PERIOD/4);
        assert (uart_en_o === 1'b0) else stop_on_error("UART enabled by an unmapped address");
        @(negedge clk);
        dev_strobe_i = 1'b0;
        repeat (20)
        begin
            assert (dev_ready_o === 1'b0) else stop_on_error("ready pulse on an unmapped address");
            assert (dev_rdata_o === '0)
                else stop_on_error($sformatf("FAILED dev_rdata_o: got %h, expected 0",
                                             dev_rdata_o));
            assert (uart_en_o === 1'b0 && m_arvalid_o === 1'b0)
                else stop_on_error("a device was accessed through an unmapped address");
            @(negedge clk);
        end
        dev_addr_i = '0;
    endtask

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error("timeout, the tests did not finish in time");
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial
    begin
        seed_ret     = $urandom(SEED);
        rst          = 1'b1;
        dev_strobe_i = 1'b0;
        dev_addr_i   = '0;
        dev_we_i     = 1'b0;
        dev_be_i     = '0;
        dev_wdata_i  = '0;
        verify_reset_release();
        access_uart_reg(1'b0, 32'hC000_0008, 2'h2);
        access_uart_reg(1'b1, 32'hC000_000C, 2'h3);
        read_spi_regs();
        stall_address_phase();
        probe_unmapped();
        $display("Verification passed");
        $finish;
    end

endmodule

/* flist.f */
src/soc_pkg.sv
src/dev_map_pkg.sv
src/dev_bus_if.sv
src/reset_stretch.sv
src/dev_decoder.sv
src/axil_rd_bridge.sv
src/dev_fabric_top.sv
tb/tb_dev_fabric.sv

/* run.sh */
#!/bin/sh
# compile and run the device fabric testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_dev_fabric -f flist.f -Mdir obj_dir \
    && ./obj_dir/Vtb_dev_fabric 2>&1 | tee sim.log

# pass only if the testbench printed its pass line
grep -q "^Verification passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
